// ==== common/sens_gamma_cfg_if.sv ====
// Gamma configuration bundle from the command decoder (ctrl) to the gamma lookup (lut)
interface sens_gamma_cfg_if;
    import sens_pkg::*;

    logic   gamma_en;    // lookup enable level
    logic   tbl_addr_we; // load table write address
    logic   tbl_data_we; // write entry, then address++
    gbyte_t tbl_wdata;   // address or entry, valid with a strobe

    modport ctrl (
        output gamma_en,
        output tbl_addr_we,
        output tbl_data_we,
        output tbl_wdata
    );

    modport lut (
        input gamma_en,
        input tbl_addr_we,
        input tbl_data_we,
        input tbl_wdata
    );

endinterface

// ==== common/sens_pkg.sv ====
// Sensor channel package with widths, register map, mode bits and pixel types, imported by all RTL
package sens_pkg;

    // data path widths
    localparam int PXD_W      = 12; // sensor pixel
    localparam int GAMMA_W    = 8;  // gamma output byte
    localparam int GAMMA_AW   = 8;  // 256 table entries
    localparam int DOUT_W     = 16; // packed output word
    localparam int CMD_DATA_W = 32; // command payload
    localparam int CMD_BYTES  = 6;  // AL, AH, D0..D3
    localparam int CHN_ADDR_W = 11; // compared command address bits

    // register map relative to the channel base
    localparam logic [CHN_ADDR_W-1:0] SENSOR_CTRL_RADDR = 'h000; // mode register
    localparam logic [CHN_ADDR_W-1:0] SENSOR_CTRL_MASK  = 'h7ff; // single location
    localparam logic [CHN_ADDR_W-1:0] SENS_GAMMA_RADDR  = 'h038; // gamma group 'h38..'h3b
    localparam logic [CHN_ADDR_W-1:0] SENS_GAMMA_MASK   = 'h7fc; // 4 locations
    localparam int SENS_GAMMA_CTRL      = 0; // gamma control
    localparam int SENS_GAMMA_ADDR_DATA = 1; // table address or table data

    // bit positions
    localparam int SENSOR_16BIT_BIT   = 8;  // 1 selects 16-bit bypass
    localparam int SENS_GAMMA_MODE_EN = 3;  // 1 enables the table lookup
    localparam int GAMMA_SEL_BIT      = 20; // 1 address word, 0 data word

    typedef logic [PXD_W-1:0]   pix_t;   // raw pixel
    typedef logic [GAMMA_W-1:0] gbyte_t; // gamma byte
    typedef logic [DOUT_W-1:0]  dword_t; // output word

    // one gamma register word, read either as a table address or as an entry
    typedef union packed {
        struct packed {
            logic [CMD_DATA_W-1:GAMMA_SEL_BIT+1] rsv;  // unused upper bits
            logic                                sel;  // 1 here
            logic [GAMMA_SEL_BIT-1:GAMMA_AW]     pad;  // unused
            logic [GAMMA_AW-1:0]                 addr; // new write address
        } av;
        struct packed {
            logic [CMD_DATA_W-1:GAMMA_SEL_BIT+1] rsv;   // unused upper bits
            logic                                sel;   // 0 here
            logic [GAMMA_SEL_BIT-1:GAMMA_W]      pad;   // unused
            logic [GAMMA_W-1:0]                  entry; // table byte
        } dv;
    } gamma_word_t;

endpackage

// ==== hw/cmd/sens_cmd_decoder.sv ====
// Byte-serial command decoder holding the mode bit and gamma control, instantiated by the channel top
module sens_cmd_decoder #(
    parameter logic [sens_pkg::CHN_ADDR_W-1:0] SENSOR_BASE_ADDR = 'h400 // 'h40 aligned channel base
) (
    input  logic           mclk,
    input  logic           rst_i,
    input  logic [7:0]     cmd_ad_i,  // AL, AH, D0..D3
    input  logic           cmd_stb_i, // high with AL
    output logic           bit16_o,   // 16-bit bypass mode
    sens_gamma_cfg_if.ctrl cfg
);
    import sens_pkg::*;

    localparam int SR_W  = 8 * CMD_BYTES;
    localparam int CNT_W = $clog2(CMD_BYTES);
    localparam logic [CHN_ADDR_W-1:0] CTRL_ADDR  = SENSOR_BASE_ADDR + SENSOR_CTRL_RADDR;
    localparam logic [CHN_ADDR_W-1:0] GAMMA_ADDR = SENSOR_BASE_ADDR + SENS_GAMMA_RADDR;

    logic [7:0]            cmd_ad_r;  // entry register
    logic                  cmd_stb_r;
    logic                  busy;      // inside a command
    logic [CNT_W-1:0]      byte_cnt;  // bytes taken so far
    logic                  cmd_done;  // full command in cmd_sr
    logic [SR_W-1:0]       cmd_sr;    // {D3,D2,D1,D0,AH,AL} when done
    logic [CHN_ADDR_W-1:0] cmd_addr;
    logic [CMD_DATA_W-1:0] cmd_data;
    gamma_word_t           gword;
    logic                  ctrl_hit;  // mode register
    logic                  gamma_hit; // anywhere in gamma group
    logic                  gctrl_we;
    logic                  gword_we;
    logic                  bit16_r;
    logic                  gamma_en_r;
    logic                  addr_we_r;
    logic                  data_we_r;
    gbyte_t                wdata_r;

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_i;
        if (cmd_stb_r || busy) begin
            cmd_sr <= {cmd_ad_r, cmd_sr[SR_W-1:8]}; // newest byte enters at the top
        end
        if (gword_we) begin
            wdata_r <= gword.dv.entry; // entry and av.addr share the low byte
        end
    end

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            cmd_stb_r <= 1'b0;
            busy      <= 1'b0;
            byte_cnt  <= '0;
            cmd_done  <= 1'b0;
        end else begin
            cmd_stb_r <= cmd_stb_i;
            cmd_done  <= 1'b0;
            if (cmd_stb_r) begin        // AL in the entry register
                busy     <= 1'b1;
                byte_cnt <= CNT_W'(1);
            end else if (busy) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == CNT_W'(CMD_BYTES - 1)) begin // D3 arriving
                    busy     <= 1'b0;
                    cmd_done <= 1'b1;
                end
            end
        end
    end

    assign cmd_addr  = cmd_sr[CHN_ADDR_W-1:0];        // AL plus low AH bits
    assign cmd_data  = cmd_sr[SR_W-1 -: CMD_DATA_W];
    assign gword     = cmd_data;
    assign ctrl_hit  = cmd_done && (((cmd_addr ^ CTRL_ADDR) & SENSOR_CTRL_MASK) == '0);
    assign gamma_hit = cmd_done && (((cmd_addr ^ GAMMA_ADDR) & SENS_GAMMA_MASK) == '0);
    assign gctrl_we  = gamma_hit && (cmd_addr[1:0] == 2'(SENS_GAMMA_CTRL));
    assign gword_we  = gamma_hit && (cmd_addr[1:0] == 2'(SENS_GAMMA_ADDR_DATA)); // 2, 3 ignored

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            bit16_r    <= 1'b0; // 8-bit mode
            gamma_en_r <= 1'b0;
            addr_we_r  <= 1'b0;
            data_we_r  <= 1'b0;
        end else begin
            if (ctrl_hit) begin
                bit16_r <= cmd_data[SENSOR_16BIT_BIT];
            end
            if (gctrl_we) begin
                gamma_en_r <= cmd_data[SENS_GAMMA_MODE_EN];
            end
            addr_we_r <= gword_we && gword.av.sel;  // address view
            data_we_r <= gword_we && !gword.dv.sel; // data view
        end
    end

    assign bit16_o         = bit16_r;
    assign cfg.gamma_en    = gamma_en_r;
    assign cfg.tbl_addr_we = addr_we_r;
    assign cfg.tbl_data_we = data_we_r;
    assign cfg.tbl_wdata   = wdata_r;

    // a new AL must not arrive before D3 of the current command
    a_no_stb_in_cmd: assert property (@(posedge mclk) disable iff (rst_i)
        busy |-> !cmd_stb_r)
        else $error("command strobe inside a command");

endmodule

// ==== hw/gamma/sens_gamma.sv ====
// Gamma lookup stage with a command-loaded 256-entry table, one pixel per mclk, fed by the channel top
module sens_gamma (
    input  logic            mclk,
    input  logic            rst_i,
    sens_gamma_cfg_if.lut   cfg,
    input  sens_pkg::pix_t  pxd_i,  // raw pixel
    input  logic            hact_i, // line active
    input  logic            sof_i,
    input  logic            eof_i,
    output sens_pkg::gbyte_t gpxd_o, // one cycle after pxd_i
    output logic            ghact_o,
    output logic            gsof_o,
    output logic            geof_o
);
    import sens_pkg::*;

    gbyte_t              tbl [2**GAMMA_AW]; // gamma table
    logic [GAMMA_AW-1:0] waddr;             // next entry to write
    logic [GAMMA_AW-1:0] raddr;             // pixel msbs

    assign raddr = pxd_i[PXD_W-1 -: GAMMA_AW];

    // write pointer, wraps at 256
    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            waddr <= '0;
        end else if (cfg.tbl_addr_we) begin
            waddr <= cfg.tbl_wdata;
        end else if (cfg.tbl_data_we) begin
            waddr <= waddr + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (cfg.tbl_data_we) begin
            tbl[waddr] <= cfg.tbl_wdata;
        end
    end

    // registered lookup, or plain msbs when disabled
    always_ff @(posedge mclk) begin
        if (cfg.gamma_en) begin
            gpxd_o <= tbl[raddr];
        end else begin
            gpxd_o <= pxd_i[PXD_W-1 -: GAMMA_W];
        end
    end

    // markers follow the pixel by one cycle
    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            ghact_o <= 1'b0;
            gsof_o  <= 1'b0;
            geof_o  <= 1'b0;
        end else begin
            ghact_o <= hact_i;
            gsof_o  <= sof_i;
            geof_o  <= eof_i;
        end
    end

    // the decoder issues at most one table strobe per command
    a_one_strobe: assert property (@(posedge mclk) disable iff (rst_i)
        !(cfg.tbl_addr_we && cfg.tbl_data_we))
        else $error("gamma address and data strobes together");

endmodule

// ==== hw/sens_pixel_pack.sv ====
// Output packer merging the 16-bit bypass and paired gamma bytes into words with line and frame marks
module sens_pixel_pack (
    input  logic             mclk,
    input  logic             rst_i,
    input  logic             bit16_i, // 1 bypass, 0 gamma pairs
    input  sens_pkg::pix_t   pxd_i,   // raw pixel, cycle n
    input  logic             hact_i,
    input  logic             sof_i,
    input  logic             eof_i,
    input  sens_pkg::gbyte_t gpxd_i,  // gamma byte, cycle n+1
    input  logic             ghact_i,
    input  logic             gsof_i,
    input  logic             geof_i,
    output sens_pkg::dword_t dout_o,  // cycle n+2
    output logic             dout_valid_o,
    output logic             last_in_line_o,
    output logic             sof_o,
    output logic             eof_o
);
    import sens_pkg::*;

    pix_t   bp_pxd_r;   // bypass pixel aligned with gamma stage
    logic   bp_hact_r;
    logic   bp_sof_r;
    logic   bp_eof_r;
    logic   phase_r;    // 1 while holding the first byte of a pair
    gbyte_t first_r;    // earlier byte of the pair
    dword_t word_w;
    logic   valid_w;
    logic   sof_w;
    logic   eof_w;

    assign word_w  = bit16_i ? {bp_pxd_r, {(DOUT_W - PXD_W){1'b0}}} : {gpxd_i, first_r};
    assign valid_w = bit16_i ? bp_hact_r : (ghact_i && phase_r); // 2nd of pair in 8-bit
    assign sof_w   = bit16_i ? bp_sof_r : gsof_i;
    assign eof_w   = bit16_i ? bp_eof_r : geof_i;

    always_ff @(posedge mclk) begin
        bp_pxd_r <= pxd_i;
        if (ghact_i && !phase_r) begin
            first_r <= gpxd_i;
        end
        if (valid_w) begin
            dout_o <= word_w;
        end
    end

    always_ff @(posedge mclk or posedge rst_i) begin
        if (rst_i) begin
            bp_hact_r      <= 1'b0;
            bp_sof_r       <= 1'b0;
            bp_eof_r       <= 1'b0;
            phase_r        <= 1'b0;
            dout_valid_o   <= 1'b0;
            last_in_line_o <= 1'b0;
            sof_o          <= 1'b0;
            eof_o          <= 1'b0;
        end else begin
            bp_hact_r <= hact_i;
            bp_sof_r  <= sof_i;
            bp_eof_r  <= eof_i;
            if (ghact_i) begin
                phase_r <= !phase_r; // toggles on every active pixel
            end
            dout_valid_o   <= valid_w;
            last_in_line_o <= valid_w && !hact_i; // hact_i is the following pixel
            sof_o          <= sof_w;
            eof_o          <= eof_w;
        end
    end

    // 8-bit pairs leave at most every other cycle
    a_pair_rate: assert property (@(posedge mclk) disable iff (rst_i)
        (dout_valid_o && !bit16_i) |=> !(dout_valid_o && !bit16_i))
        else $error("back-to-back valid in 8-bit mode");

endmodule

// ==== hw/sensor_channel.sv ====
// Sensor channel top joining the command decoder, gamma lookup and output packer on mclk
module sensor_channel #(
    parameter logic [sens_pkg::CHN_ADDR_W-1:0] SENSOR_BASE_ADDR = 'h400 // channel register base
) (
    input  logic                       mclk,
    input  logic                       rst_i,
    input  logic [7:0]                 cmd_ad_i,  // byte-serial command
    input  logic                       cmd_stb_i, // with first byte
    input  logic [sens_pkg::PXD_W-1:0] pxd_i,     // sensor pixel
    input  logic                       hact_i,
    input  logic                       sof_i,
    input  logic                       eof_i,
    output logic [sens_pkg::DOUT_W-1:0] dout_o,
    output logic                       dout_valid_o,
    output logic                       last_in_line_o,
    output logic                       sof_o,
    output logic                       eof_o
);
    import sens_pkg::*;

    sens_gamma_cfg_if u_gamma_cfg ();

    logic   bit16;  // bypass mode
    gbyte_t gpxd;   // gamma path
    logic   ghact;
    logic   gsof;
    logic   geof;

    sens_cmd_decoder #(
        .SENSOR_BASE_ADDR (SENSOR_BASE_ADDR)
    ) u_cmd_decoder (
        .mclk      (mclk),
        .rst_i     (rst_i),
        .cmd_ad_i  (cmd_ad_i),
        .cmd_stb_i (cmd_stb_i),
        .bit16_o   (bit16),
        .cfg       (u_gamma_cfg)
    );

    sens_gamma u_gamma (
        .mclk    (mclk),
        .rst_i   (rst_i),
        .cfg     (u_gamma_cfg),
        .pxd_i   (pxd_i),
        .hact_i  (hact_i),
        .sof_i   (sof_i),
        .eof_i   (eof_i),
        .gpxd_o  (gpxd),
        .ghact_o (ghact),
        .gsof_o  (gsof),
        .geof_o  (geof)
    );

    sens_pixel_pack u_pixel_pack (
        .mclk           (mclk),
        .rst_i          (rst_i),
        .bit16_i        (bit16),
        .pxd_i          (pxd_i),   // raw stream, bypass side
        .hact_i         (hact_i),
        .sof_i          (sof_i),
        .eof_i          (eof_i),
        .gpxd_i         (gpxd),
        .ghact_i        (ghact),
        .gsof_i         (gsof),
        .geof_i         (geof),
        .dout_o         (dout_o),
        .dout_valid_o   (dout_valid_o),
        .last_in_line_o (last_in_line_o),
        .sof_o          (sof_o),
        .eof_o          (eof_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the sensor channel testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f sim.f --top-module tb_sensor_channel > sim.log 2>&1 \
    && ./obj_dir/Vtb_sensor_channel >> sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== sim.f ====
common/sens_pkg.sv
common/sens_gamma_cfg_if.sv
hw/cmd/sens_cmd_decoder.sv
hw/gamma/sens_gamma.sv
hw/sens_pixel_pack.sv
hw/sensor_channel.sv
testbench/tb_sensor_channel.sv

// ==== testbench/tb_sensor_channel.sv ====
// Self-checking testbench for the sensor channel, LFSR pixels and commands checked by a cycle model
module tb_sensor_channel;
    timeunit 1ns;
    timeprecision 100ps;
    import sens_pkg::*;

    localparam logic [10:0] BASE     = 11'h400;
    localparam logic [10:0] GAMMA_RG = BASE + 11'h038; // gamma ctrl, +1 address/data
    localparam logic [31:0] POLY     = 32'h80200003;   // x^32+x^22+x^2+x+1
    localparam int LINES    = 3;
    localparam int FRAMES   = 8;
    localparam int MAX_W    = 16;
    localparam int MAX_GAP  = 4;
    localparam int SETTLE   = 8;  // idle cycles after a command
    localparam int N_CMDS   = 272;
    localparam int STIM_MAX = FRAMES * (LINES * (MAX_W + MAX_GAP) + 2) + N_CMDS * 6
                              + 16 * SETTLE + 8;
    localparam int TIMEOUT  = 2 * STIM_MAX;

    typedef struct packed {
        logic   valid;
        logic   last;
        logic   sof;
        logic   eof;
        dword_t word;
    } exp_t;

    logic        mclk;
    logic        rst_i;
    logic [7:0]  cmd_ad_i;
    logic        cmd_stb_i;
    pix_t        pxd_i;
    logic        hact_i;
    logic        sof_i;
    logic        eof_i;
    dword_t      dout_o;
    logic        dout_valid_o;
    logic        last_in_line_o;
    logic        sof_o;
    logic        eof_o;

    logic [31:0] lfsr = 32'h26b947ae;
    gbyte_t      m_tbl [256];   // model table
    logic [7:0]  m_waddr;
    logic        m_bit16;
    logic        m_gamma_en;
    logic        m_phase;       // 1 after the first pixel of a pair
    gbyte_t      m_first;
    exp_t        exp_q [$];     // words in flight, oldest first
    int          cycle_cnt = 0;

    sensor_channel #(
        .SENSOR_BASE_ADDR (BASE)
    ) u_sensor_channel (
        .mclk           (mclk),
        .rst_i          (rst_i),
        .cmd_ad_i       (cmd_ad_i),
        .cmd_stb_i      (cmd_stb_i),
        .pxd_i          (pxd_i),
        .hact_i         (hact_i),
        .sof_i          (sof_i),
        .eof_i          (eof_i),
        .dout_o         (dout_o),
        .dout_valid_o   (dout_valid_o),
        .last_in_line_o (last_in_line_o),
        .sof_o          (sof_o),
        .eof_o          (eof_o)
    );

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk; // 100 ns period
    end

    always @(posedge mclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            stop_run();
        end
    end

    task stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    // one output bit per LFSR step, msb first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? POLY : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    task check_word(input dword_t got, input dword_t exp);
        if (got !== exp) begin
            $display("[ERROR] dout_o: got 0x%h expected 0x%h", got, exp);
            stop_run();
        end
    endtask

    task check_flag(input bit got, input bit exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task compare_outputs(input exp_t e);
        if (e.valid && !dout_valid_o) begin
            $display("expected output word 0x%h did not appear", e.word);
            stop_run();
        end
        if (!e.valid && dout_valid_o) begin
            $display("output word 0x%h appeared when none was expected", dout_o);
            stop_run();
        end
        if (e.valid) begin
            check_word(dout_o, e.word);
        end
        check_flag(last_in_line_o, e.last, "last_in_line_o");
        check_flag(sof_o, e.sof, "sof_o");
        check_flag(eof_o, e.eof, "eof_o");
    endtask

    // model of one input cycle, its word leaves 2 edges after it is sampled
    task push_expect(input pix_t px, input logic act, input logic sf, input logic ef);
        exp_t   e;
        exp_t   prev;
        gbyte_t b;
        e     = '0;
        e.sof = sf;
        e.eof = ef;
        prev  = exp_q.pop_back();
        if (prev.valid && !act) begin
            prev.last = 1'b1; // next pixel inactive ends the line
        end
        exp_q.push_back(prev);
        if (act) begin
            b = m_gamma_en ? m_tbl[px[11:4]] : px[11:4];
            if (m_bit16) begin
                e.valid = 1'b1;
                e.word  = {px, 4'h0};
            end else if (m_phase) begin
                e.valid = 1'b1;
                e.word  = {b, m_first}; // earlier byte in the lsb
            end else begin
                m_first = b;
            end
            m_phase = !m_phase;
        end
        exp_q.push_back(e);
    endtask

    task automatic drive_cycle(input logic [7:0] ad, input logic stb, input pix_t px,
                               input logic act, input logic sf, input logic ef);
        exp_t e;
        @(posedge mclk);
        cmd_ad_i  <= ad;
        cmd_stb_i <= stb;
        pxd_i     <= px;
        hact_i    <= act;
        sof_i     <= sf;
        eof_i     <= ef;
        push_expect(px, act, sf, ef);
        @(negedge mclk);  // outputs settled
        e = exp_q.pop_front();
        compare_outputs(e);
    endtask

    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            drive_cycle(8'h00, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    // register decode as the register map defines it
    task apply_cmd(input logic [10:0] addr, input logic [31:0] data);
        if (addr == BASE) begin
            m_bit16 = data[8];
        end
        if (addr[10:2] == GAMMA_RG[10:2]) begin
            if (addr[1:0] == 2'd0) begin
                m_gamma_en = data[3];
            end else if (addr[1:0] == 2'd1 && data[20]) begin
                m_waddr = data[7:0];
            end else if (addr[1:0] == 2'd1) begin
                m_tbl[m_waddr] = data[7:0];
                m_waddr        = m_waddr + 8'd1;
            end
        end
    endtask

    task automatic send_cmd(input logic [10:0] addr, input logic [31:0] data);
        drive_cycle(addr[7:0], 1'b1, '0, 1'b0, 1'b0, 1'b0);             // AL
        drive_cycle({5'b00000, addr[10:8]}, 1'b0, '0, 1'b0, 1'b0, 1'b0); // AH
        drive_cycle(data[7:0], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(data[15:8], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(data[23:16], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(data[31:24], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        apply_cmd(addr, data);
    endtask

    // even widths 4..16, gaps 1..4, sof on the first pixel, eof after the last line
    task automatic run_frame();
        int ln;
        int i;
        int w;
        int gap;
        for (ln = 0; ln < LINES; ln++) begin
            w   = 4 + 2 * int'(take_bits(3) % 7);
            gap = 1 + int'(take_bits(2));
            for (i = 0; i < w; i++) begin
                drive_cycle(8'h00, 1'b0, pix_t'(take_bits(12)), 1'b1,
                            ln == 0 && i == 0, 1'b0);
            end
            for (i = 0; i < gap; i++) begin
                drive_cycle(8'h00, 1'b0, pix_t'(take_bits(12)), 1'b0,
                            1'b0, ln == LINES - 1 && i == 0);
            end
        end
    endtask

    initial begin
        logic [31:0] word;
        int          k;
        rst_i      = 1'b1;
        cmd_ad_i   = 8'h00;
        cmd_stb_i  = 1'b0;
        pxd_i      = '0;
        hact_i     = 1'b0;
        sof_i      = 1'b0;
        eof_i      = 1'b0;
        m_bit16    = 1'b0;
        m_gamma_en = 1'b0;
        m_phase    = 1'b0;
        m_waddr    = 8'h00;
        m_first    = 8'h00;
        exp_q.push_back('0); // pipeline holds two idle cycles
        exp_q.push_back('0);
        repeat (2) @(posedge mclk);
        rst_i <= 1'b0;

        repeat (2) run_frame(); // 8-bit, gamma off

        word     = take_bits(32);
        word[20] = 1'b1;        // address word, random start
        send_cmd(GAMMA_RG + 11'd1, word);
        for (k = 0; k < 256; k++) begin
            word     = take_bits(32);
            word[20] = 1'b0;    // data word
            send_cmd(GAMMA_RG + 11'd1, word);
        end
        send_cmd(GAMMA_RG, 32'h0000_0008);
        idle_cycles(SETTLE);
        repeat (2) run_frame(); // 8-bit through the table

        send_cmd(BASE, 32'h0000_0100);
        idle_cycles(SETTLE);
        repeat (2) run_frame(); // 16-bit bypass

        send_cmd(BASE, 32'h0000_0000);
        send_cmd(BASE + 11'h040, 32'h0000_0100);     // neighbour channel mode
        send_cmd(GAMMA_RG + 11'h040, 32'h0000_0000); // neighbour gamma disable
        send_cmd(GAMMA_RG + 11'd2, take_bits(32));
        send_cmd(GAMMA_RG + 11'd3, take_bits(32));
        send_cmd(11'h123, 32'hffff_ffff);
        send_cmd(BASE + 11'd1, 32'h0000_0100);       // next to the mode register
        idle_cycles(SETTLE);
        repeat (2) run_frame(); // still 8-bit, same table

        idle_cycles(4);
        $display("Testbench passed");
        $finish;
    end

endmodule
